// File: logic/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// data word
`define ALU_WORD_W 32

// destination register address
`define ALU_RADDR_W 5

// shift amount, low bits of operand 1
`define ALU_SHAMT_W 5

// decoded operation and result class
`define ALU_OP_W 8
`define ALU_SEL_W 3

`endif

// File: logic/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

    typedef logic [`ALU_WORD_W-1:0] word_t;
    typedef logic [2*`ALU_WORD_W-1:0] dword_t;

    // result class, picks the writeback source
    typedef enum logic [`ALU_SEL_W-1:0] {
        SEL_NONE  = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alu_sel_e;

    typedef enum logic [`ALU_OP_W-1:0] {
        OP_NOP = 8'h00, OP_SRL = 8'h02, OP_SRA = 8'h03, OP_MOVZ = 8'h0a,
        OP_MOVN = 8'h0b, OP_MFHI = 8'h10, OP_MTHI = 8'h11, OP_MFLO = 8'h12,
        OP_MTLO = 8'h13, OP_MULT = 8'h18, OP_MULTU = 8'h19, OP_ADD = 8'h20,
        OP_ADDU = 8'h21, OP_SUB = 8'h22, OP_SUBU = 8'h23, OP_AND = 8'h24,
        OP_OR = 8'h25, OP_XOR = 8'h26, OP_NOR = 8'h27, OP_SLT = 8'h2a,
        OP_SLTU = 8'h2b, OP_SLL = 8'h7c, OP_MADD = 8'ha6, OP_MADDU = 8'ha8,
        OP_MUL = 8'ha9, OP_MSUB = 8'haa, OP_MSUBU = 8'hab, OP_CLZ = 8'hb0,
        OP_CLO = 8'hb1
    } alu_op_e;

    typedef struct packed {
        alu_sel_e alusel;
        alu_op_e aluop;
        word_t reg1;
        word_t reg2;
        logic [`ALU_RADDR_W-1:0] wd;
        logic wreg;
    } exe_req_t;

    typedef struct packed {
        word_t wdata;
        logic [`ALU_RADDR_W-1:0] wd;
        logic wreg;
    } exe_wb_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

    // whole for accumulate arithmetic, halves for the register write
    typedef union packed {
        dword_t whole;
        hilo_t half;
    } hilo_u;

endpackage

// File: logic/int_alu.sv
`include "alu_config.svh"

module int_alu
    import alu_pkg::*;
(
    input  exe_req_t req_i,
    output word_t    alu_res_o,
    output logic     ov_o
);

    logic [`ALU_SHAMT_W-1:0] shamt;
    word_t sum;
    word_t diff;
    logic add_ov;
    logic sub_ov;

    // scan upward so the highest set bit wins
    function automatic logic [5:0] lead_zeros(input word_t w);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < `ALU_WORD_W; i++) begin
            if (w[i]) begin
                n = 6'(`ALU_WORD_W - 1 - i);
            end
        end
        return n;
    endfunction

    assign shamt = req_i.reg1[`ALU_SHAMT_W-1:0];
    assign sum = req_i.reg1 + req_i.reg2;
    assign diff = req_i.reg1 - req_i.reg2;

    // same-sign operands, result sign flipped
    assign add_ov = (req_i.reg1[`ALU_WORD_W-1] == req_i.reg2[`ALU_WORD_W-1]) &&
                    (sum[`ALU_WORD_W-1] != req_i.reg1[`ALU_WORD_W-1]);
    assign sub_ov = (req_i.reg1[`ALU_WORD_W-1] != req_i.reg2[`ALU_WORD_W-1]) &&
                    (diff[`ALU_WORD_W-1] != req_i.reg1[`ALU_WORD_W-1]);

    // only the trapping forms report overflow
    assign ov_o = ((req_i.aluop == OP_ADD) && add_ov) ||
                  ((req_i.aluop == OP_SUB) && sub_ov);

    always_comb begin
        case (req_i.aluop)
            OP_AND: alu_res_o = req_i.reg1 & req_i.reg2;
            OP_OR: alu_res_o = req_i.reg1 | req_i.reg2;
            OP_XOR: alu_res_o = req_i.reg1 ^ req_i.reg2;
            OP_NOR: alu_res_o = ~(req_i.reg1 | req_i.reg2);
            OP_SLL: alu_res_o = req_i.reg2 << shamt;
            OP_SRL: alu_res_o = req_i.reg2 >> shamt;
            OP_SRA: alu_res_o = word_t'($signed(req_i.reg2) >>> shamt);
            OP_ADD, OP_ADDU: begin
                alu_res_o = sum;
            end
            OP_SUB, OP_SUBU: begin
                alu_res_o = diff;
            end
            OP_SLT: begin
                alu_res_o = word_t'($signed(req_i.reg1) < $signed(req_i.reg2));
            end
            OP_SLTU: begin
                alu_res_o = word_t'(req_i.reg1 < req_i.reg2);
            end
            OP_CLZ: begin
                alu_res_o = word_t'(lead_zeros(req_i.reg1));
            end
            // leading ones are leading zeros of the complement
            OP_CLO: begin
                alu_res_o = word_t'(lead_zeros(~req_i.reg1));
            end
            default: alu_res_o = '0;
        endcase
    end

endmodule

// File: logic/mul_unit.sv
`include "alu_config.svh"

module mul_unit
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  exe_req_t req_i,
    input  hilo_t    hilo_i,
    output word_t    prod_lo_o,
    output logic     hilo_we_o,
    output hilo_u    hilo_wdata_o,
    output logic     stall_o,
    output logic     mul_stall_o
);

    logic signed_op;
    logic acc_op;
    logic sub_op;
    logic neg;
    logic step_q;
    word_t mag1;
    word_t mag2;
    dword_t mag_prod;
    dword_t prod;
    dword_t acc_q;

    assign signed_op = req_i.aluop inside {OP_MULT, OP_MUL, OP_MADD, OP_MSUB};
    assign acc_op = req_i.aluop inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    assign sub_op = req_i.aluop inside {OP_MSUB, OP_MSUBU};

    // multiply magnitudes, then put the sign back
    assign mag1 = (signed_op && req_i.reg1[`ALU_WORD_W-1]) ? -req_i.reg1 : req_i.reg1;
    assign mag2 = (signed_op && req_i.reg2[`ALU_WORD_W-1]) ? -req_i.reg2 : req_i.reg2;
    assign neg = signed_op && (req_i.reg1[`ALU_WORD_W-1] ^ req_i.reg2[`ALU_WORD_W-1]);
    assign mag_prod = dword_t'(mag1) * dword_t'(mag2);
    assign prod = neg ? -mag_prod : mag_prod;
    assign prod_lo_o = prod[`ALU_WORD_W-1:0];

    // first accumulate cycle holds the pipe
    assign stall_o = acc_op && !step_q;
    assign mul_stall_o = acc_op;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            step_q <= 1'b0;
        end else begin
            step_q <= stall_o;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_o) begin
            acc_q <= prod;
        end
    end

    always_comb begin
        hilo_we_o = 1'b0;
        hilo_wdata_o.whole = prod;
        if (req_i.aluop inside {OP_MULT, OP_MULTU}) begin
            hilo_we_o = 1'b1;
        end else if (acc_op && step_q) begin
            hilo_we_o = 1'b1;
            hilo_wdata_o.whole = sub_op ? dword_t'(hilo_i) - acc_q : dword_t'(hilo_i) + acc_q;
        end
    end

    // accumulate request stays put across the stalled edge
    a_req_held_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n_i) stall_o |=> $stable(req_i)
    );

endmodule

// File: logic/hilo_unit.sv
module hilo_unit
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  exe_req_t req_i,
    input  logic     mul_we_i,
    input  hilo_u    mul_wdata_i,
    output hilo_t    hilo_o,
    output word_t    move_res_o
);

    hilo_t hilo_q;
    logic mthi;
    logic mtlo;

    assign mthi = (req_i.aluop == OP_MTHI);
    assign mtlo = (req_i.aluop == OP_MTLO);

    // multiplier write wins, moves touch one half only
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hilo_q <= '0;
        end else if (mul_we_i) begin
            hilo_q <= mul_wdata_i.half;
        end else if (mthi) begin
            hilo_q.hi <= req_i.reg1;
        end else if (mtlo) begin
            hilo_q.lo <= req_i.reg1;
        end
    end

    assign hilo_o = hilo_q;

    always_comb begin
        case (req_i.aluop)
            OP_MOVZ, OP_MOVN: move_res_o = req_i.reg1;
            OP_MFHI: move_res_o = hilo_q.hi;
            OP_MFLO: move_res_o = hilo_q.lo;
            default: move_res_o = '0;
        endcase
    end

    a_single_writer: assert property (
        @(posedge clk) disable iff (!arst_n_i) !(mul_we_i && (mthi || mtlo))
    );

endmodule

// File: logic/ex_result_reg.sv
`include "alu_config.svh"

module ex_result_reg
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  exe_req_t req_i,
    input  word_t    alu_res_i,
    input  logic     ov_i,
    input  word_t    prod_lo_i,
    input  word_t    move_res_i,
    input  logic     mul_stall_i,
    output exe_wb_t  wb_o
);

    word_t wdata_d;
    word_t wdata_q;
    logic [$bits(req_i.wd)-1:0] wd_q;
    logic wreg_q;

    always_comb begin
        case (req_i.alusel)
            SEL_LOGIC, SEL_SHIFT, SEL_ARITH: wdata_d = alu_res_i;
            SEL_MOVE: wdata_d = move_res_i;
            SEL_MUL: wdata_d = prod_lo_i;
            default: wdata_d = '0;
        endcase
    end

    // no register write on overflow or while accumulating
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wreg_q <= 1'b0;
        end else begin
            wreg_q <= req_i.wreg && !ov_i && !mul_stall_i;
        end
    end

    always_ff @(posedge clk) begin
        wdata_q <= wdata_d;
        wd_q <= req_i.wd;
    end

    assign wb_o = '{wdata: wdata_q, wd: wd_q, wreg: wreg_q};

    // signed add whose sum sign breaks from same-sign operands
    a_ov_no_write: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (req_i.aluop == OP_ADD &&
         req_i.reg1[`ALU_WORD_W-1] == req_i.reg2[`ALU_WORD_W-1] &&
         alu_res_i[`ALU_WORD_W-1] != req_i.reg1[`ALU_WORD_W-1]) |=> !wb_o.wreg
    );

endmodule

// File: logic/ex_stage.sv
module ex_stage
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  exe_req_t req_i,
    output exe_wb_t  wb_o,
    output logic     stall_o
);

    word_t alu_res;
    logic ov;
    word_t prod_lo;
    logic mul_we;
    hilo_u mul_wdata;
    logic mul_stall;
    hilo_t hilo;
    word_t move_res;

    int_alu u_int_alu (
        .req_i     (req_i),
        .alu_res_o (alu_res),
        .ov_o      (ov)
    );

    mul_unit u_mul_unit (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .hilo_i       (hilo),
        .prod_lo_o    (prod_lo),
        .hilo_we_o    (mul_we),
        .hilo_wdata_o (mul_wdata),
        .stall_o      (stall_o),
        .mul_stall_o  (mul_stall)
    );

    hilo_unit u_hilo_unit (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .mul_we_i    (mul_we),
        .mul_wdata_i (mul_wdata),
        .hilo_o      (hilo),
        .move_res_o  (move_res)
    );

    ex_result_reg u_ex_result_reg (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .alu_res_i   (alu_res),
        .ov_i        (ov),
        .prod_lo_i   (prod_lo),
        .move_res_i  (move_res),
        .mul_stall_i (mul_stall),
        .wb_o        (wb_o)
    );

endmodule

// File: verification/ex_checker.sv
module ex_checker
    import alu_pkg::*;
(
    input  logic     clk,
    input  exe_req_t req_i,
    input  exe_wb_t  wb_i,
    input  logic     stall_i,
    input  logic     exp_valid_i,
    input  exe_wb_t  exp_i,
    output int       vec_cnt_o,
    output int       err_cnt_o
);

    logic pend_q;
    logic stall_q;
    exe_wb_t exp_q;
    alu_op_e op_q;
    int stalls = 0;
    int exp_stalls = 0;
    int vec_err = 0;
    int vec_cnt = 0;
    int err_cnt = 0;

    assign vec_cnt_o = vec_cnt;
    assign err_cnt_o = err_cnt;

    task automatic compare_field(input string name, input word_t expv, input word_t gotv);
        if (expv !== gotv) begin
            $display("[ERROR] %s expected %h got %h", name, expv, gotv);
            vec_err++;
        end
    endtask

    // what the request latched at this edge should produce
    always @(posedge clk) begin
        pend_q <= exp_valid_i;
        stall_q <= stall_i;
        exp_q <= exp_i;
        op_q <= req_i.aluop;
    end

    // wb_o is steady mid-cycle
    always @(negedge clk) begin
        if (pend_q) begin
            compare_field("wb_o.wdata", exp_q.wdata, wb_i.wdata);
            compare_field("wb_o.wd", word_t'(exp_q.wd), word_t'(wb_i.wd));
            compare_field("wb_o.wreg", word_t'(exp_q.wreg), word_t'(wb_i.wreg));
            if (stall_q) begin
                stalls++;
            end else begin
                // accumulate ops hold the pipe for exactly one cycle
                exp_stalls = (op_q inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) ? 1 : 0;
                compare_field("stall_o cycles", word_t'(exp_stalls), word_t'(stalls));
                vec_cnt++;
                err_cnt = err_cnt + vec_err;
                if (vec_err == 0) begin
                    $display("vector %0d aluop %h: ok", vec_cnt, op_q);
                end else begin
                    $display("vector %0d aluop %h: %0d mismatches", vec_cnt, op_q, vec_err);
                end
                stalls = 0;
                vec_err = 0;
            end
        end
    end

endmodule

// File: verification/tb_ex_stage.sv
module tb_ex_stage
    import alu_pkg::*;
();

    logic clk;
    logic arst_n_i;
    exe_req_t req;
    exe_wb_t wb;
    logic stall;
    logic exp_valid;
    exe_wb_t exp;
    int vec_cnt;
    int err_cnt;
    int fd;
    int n;
    string line;
    logic [7:0] op;
    logic [2:0] sel;
    word_t r1;
    word_t r2;
    word_t e_wdata;
    logic [4:0] wd;
    logic wreg;
    logic e_wreg;
    bit timed_out;
    bit stop;

    ex_stage dut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (req),
        .wb_o     (wb),
        .stall_o  (stall)
    );

    ex_checker u_checker (
        .clk         (clk),
        .req_i       (req),
        .wb_i        (wb),
        .stall_i     (stall),
        .exp_valid_i (exp_valid),
        .exp_i       (exp),
        .vec_cnt_o   (vec_cnt),
        .err_cnt_o   (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // keep the request steady until the accumulate step is done
    task automatic wait_stall_release(output bit expired);
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (stall && cyc < 10) begin
            @(negedge clk);
            cyc++;
        end
        expired = stall;
    endtask

    initial begin
        arst_n_i = 1'b0;
        req = '0;
        exp = '0;
        exp_valid = 1'b0;
        stop = 1'b0;
        repeat (10) @(posedge clk);
        #5 arst_n_i = 1'b1;
        fd = $fopen("verification/ex_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/ex_golden.txt");
            stop = 1'b1;
        end else begin
            while (!stop && $fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                op, sel, r1, r2, wd, wreg, e_wdata, e_wreg);
                    if (n != 8) begin
                        $display("golden line could not be parsed: %s", line);
                        stop = 1'b1;
                    end else begin
                        @(posedge clk);
                        #5;
                        req = '{alusel: alu_sel_e'(sel), aluop: alu_op_e'(op),
                                reg1: r1, reg2: r2, wd: wd, wreg: wreg};
                        exp = '{wdata: e_wdata, wd: wd, wreg: e_wreg};
                        exp_valid = 1'b1;
                        wait_stall_release(timed_out);
                        if (timed_out) begin
                            $display("stall never released");
                            stop = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        // let the last request reach wb_o and be checked
        @(posedge clk);
        #5;
        exp_valid = 1'b0;
        req = '0;
        @(negedge clk);
        @(posedge clk);
        $display("%0d vectors checked, %0d errors", vec_cnt, err_cnt);
        if (!stop && err_cnt == 0 && vec_cnt > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verification/ex_golden.txt
# aluop alusel reg1 reg2 wd wreg exp_wdata exp_wreg, all hex
# alusel 0 none, 1 logic, 2 shift, 3 move, 4 arith, 5 mul
24 1 f0f0ff00 0ff0f0f0 01 1 00f0f000 1
27 1 12345678 0000ffff 02 1 edcb0000 1
7c 2 00000004 00000123 03 1 00001230 1
03 2 00000024 f0000000 04 1 ff000000 1
0a 3 deadbeef 00000000 05 1 deadbeef 1
0b 3 cafef00d 00000001 06 1 cafef00d 1
20 4 00000005 00000007 07 1 0000000c 1
20 4 7fffffff 00000001 08 1 80000000 0
21 4 7fffffff 00000001 09 1 80000000 1
22 4 80000000 00000001 0a 1 7fffffff 0
2a 4 ffffffff 00000001 0b 1 00000001 1
2b 4 ffffffff 00000001 0c 1 00000000 1
b0 4 00000000 00000000 0d 1 00000020 1
b0 4 00000002 00000000 0e 1 0000001e 1
b1 4 ffffffff 00000000 0f 1 00000020 1
11 0 11112222 00000000 00 0 00000000 0
13 0 33334444 00000000 00 0 00000000 0
10 3 00000000 00000000 10 1 11112222 1
12 3 00000000 00000000 11 1 33334444 1
18 0 fffffffe 00000003 00 0 00000000 0
10 3 00000000 00000000 12 1 ffffffff 1
12 3 00000000 00000000 13 1 fffffffa 1
19 0 ffffffff 00000002 00 0 00000000 0
10 3 00000000 00000000 14 1 00000001 1
12 3 00000000 00000000 15 1 fffffffe 1
a9 5 fffffffd 00000004 16 1 fffffff4 1
a6 0 00000002 00000003 17 1 00000000 0
10 3 00000000 00000000 18 1 00000002 1
12 3 00000000 00000000 19 1 00000004 1
ab 0 00000003 00000002 1a 1 00000000 0
10 3 00000000 00000000 1b 1 00000001 1
12 3 00000000 00000000 1c 1 fffffffe 1

// File: sources.f
+incdir+logic
logic/alu_pkg.sv
logic/int_alu.sv
logic/mul_unit.sv
logic/hilo_unit.sv
logic/ex_result_reg.sv
logic/ex_stage.sv
verification/ex_checker.sv
verification/tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_ex_stage
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
